/* noc_config_pkg.sv */
package noc_config_pkg;

  ////////////////////////////////////////////////////////////
  // mesh geometry
  ////////////////////////////////////////////////////////////

  localparam int id_x_width = 3;
  localparam int id_y_width = 3;

  ////////////////////////////////////////////////////////////
  // router slice ports
  ////////////////////////////////////////////////////////////

  localparam int num_inputs  = 2;
  localparam int num_outputs = 5;

  // index into the input ports, at least one bit.
  localparam int input_index_width = (num_inputs > 1) ? $clog2(num_inputs) : 1;

  // output numbering, also the bit order of a route.
  localparam int port_x_plus  = 0;
  localparam int port_x_minus = 1;
  localparam int port_y_plus  = 2;
  localparam int port_y_minus = 3;
  localparam int port_local   = 4;

endpackage

/* noc_flit_pkg.sv */
package noc_flit_pkg;

  import noc_config_pkg::*;

  ////////////////////////////////////////////////////////////
  // flit
  ////////////////////////////////////////////////////////////

  localparam int payload_width = 32;

  typedef enum logic {
    routing_x_y = 1'b0,  // x first, then y.
    routing_y_x = 1'b1   // y first, then x.
  } noc_routing_mode_t;

  // routing fields are only meaningful in a head flit.
  typedef struct packed {
    logic                     head;
    logic                     tail;
    noc_routing_mode_t        routing_mode;
    logic [id_x_width-1:0]    dest_x;
    logic [id_y_width-1:0]    dest_y;
    logic [payload_width-1:0] payload;
  } noc_flit_t;

  ////////////////////////////////////////////////////////////
  // route
  ////////////////////////////////////////////////////////////

  // one bit per output index.
  typedef enum logic [num_outputs-1:0] {
    route_none    = num_outputs'(0),
    route_x_plus  = num_outputs'(1 << port_x_plus),
    route_x_minus = num_outputs'(1 << port_x_minus),
    route_y_plus  = num_outputs'(1 << port_y_plus),
    route_y_minus = num_outputs'(1 << port_y_minus),
    route_local   = num_outputs'(1 << port_local)
  } noc_route_t;

endpackage

/* noc_route_selector.sv */
`timescale 1ns/100ps

module noc_route_selector
  import noc_config_pkg::*;
  import noc_flit_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [id_x_width-1:0]  id_x,
  input  logic [id_y_width-1:0]  id_y,
  input  logic                   in_valid,
  input  noc_flit_t              in_flit,
  output logic                   in_ready,
  output logic [num_outputs-1:0] request,
  output logic                   sop,
  output logic                   eop,
  input  logic                   ready
);

  ////////////////////////////////////////////////////////////
  // dimension order routing
  ////////////////////////////////////////////////////////////

  function automatic noc_route_t order_route(
    input noc_routing_mode_t mode,
    input logic [3:0]        cmp
  );
    noc_route_t route;
    if (mode == routing_x_y) begin
      case (1'b1)
        cmp[port_x_plus]:  route = route_x_plus;
        cmp[port_x_minus]: route = route_x_minus;
        cmp[port_y_plus]:  route = route_y_plus;
        cmp[port_y_minus]: route = route_y_minus;
        default:           route = route_local;
      endcase
    end else begin
      case (1'b1)
        cmp[port_y_plus]:  route = route_y_plus;
        cmp[port_y_minus]: route = route_y_minus;
        cmp[port_x_plus]:  route = route_x_plus;
        cmp[port_x_minus]: route = route_x_minus;
        default:           route = route_local;
      endcase
    end
    return route;
  endfunction

  logic [3:0] compare;
  noc_route_t route_next;
  noc_route_t route_latched;
  noc_route_t route;

  always_comb begin
    compare               = '0;
    compare[port_x_plus]  = in_flit.dest_x > id_x;
    compare[port_x_minus] = in_flit.dest_x < id_x;
    compare[port_y_plus]  = in_flit.dest_y > id_y;
    compare[port_y_minus] = in_flit.dest_y < id_y;
  end

  assign route_next = order_route(in_flit.routing_mode, compare);

  ////////////////////////////////////////////////////////////
  // packet framing
  ////////////////////////////////////////////////////////////

  assign sop = in_valid && in_flit.head;
  assign eop = in_valid && ready && in_flit.tail;

  // head uses the fresh route, body and tail the held one.
  assign route = sop ? route_next : route_latched;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      route_latched <= route_none;
    end else if (eop) begin
      route_latched <= route_none;  // packet finished.
    end else if (sop) begin
      route_latched <= route_next;
    end
  end

  assign request  = in_valid ? route : route_none;
  assign in_ready = ready;  // already steered by the switch.

endmodule

/* noc_output_arbiter.sv */
`timescale 1ns/100ps

module noc_output_arbiter
  import noc_config_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [num_inputs-1:0] request,
  input  logic [num_inputs-1:0] sop,
  input  logic [num_inputs-1:0] eop,
  input  logic                  out_ready,
  output logic [num_inputs-1:0] grant
);

  logic                         locked;
  logic [input_index_width-1:0] owner;
  logic [input_index_width-1:0] pointer;
  logic                         pick_valid;
  logic [input_index_width-1:0] pick_index;
  logic                         grant_valid;
  logic [input_index_width-1:0] grant_index;
  logic [input_index_width-1:0] next_pointer;
  logic                         transfer;
  logic                         packet_done;

  // first head request at or after the pointer.
  always_comb begin
    int idx;
    pick_valid = 1'b0;
    pick_index = pointer;
    for (int offset = num_inputs - 1; offset >= 0; offset--) begin
      idx = (int'(pointer) + offset) % num_inputs;
      if (request[idx] && sop[idx]) begin
        pick_valid = 1'b1;
        pick_index = input_index_width'(idx);
      end
    end
  end

  assign grant_valid = locked || pick_valid;
  assign grant_index = locked ? owner : pick_index;

  always_comb begin
    grant = '0;
    if (grant_valid) begin
      grant[grant_index] = 1'b1;
    end
  end

  assign transfer    = grant_valid && request[grant_index] && out_ready;
  assign packet_done = transfer && eop[grant_index];

  assign next_pointer = (grant_index == input_index_width'(num_inputs - 1)) ?
                        '0 : grant_index + 1'b1;

  ////////////////////////////////////////////////////////////
  // packet lock
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked  <= 1'b0;
      owner   <= '0;
      pointer <= '0;  // input 0 first.
    end else if (packet_done) begin
      locked  <= 1'b0;
      pointer <= next_pointer;  // skip past the winner.
    end else if (!locked && pick_valid) begin
      locked <= 1'b1;
      owner  <= pick_index;
    end
  end

endmodule

/* noc_output_switch.sv */
`timescale 1ns/100ps

module noc_output_switch
  import noc_config_pkg::*;
  import noc_flit_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [num_outputs-1:0]           request_0,
  input  logic [num_outputs-1:0]           request_1,
  input  noc_flit_t                        flit_0,
  input  noc_flit_t                        flit_1,
  input  logic                             sop_0,
  input  logic                             sop_1,
  input  logic                             eop_0,
  input  logic                             eop_1,
  output logic                             ready_0,
  output logic                             ready_1,
  output logic [num_outputs-1:0]           out_valid,
  output noc_flit_t [num_outputs-1:0]      out_flit,
  input  logic [num_outputs-1:0]           out_ready
);

  logic [num_outputs-1:0] in_request [num_inputs];
  noc_flit_t              in_flit    [num_inputs];
  logic [num_inputs-1:0]  in_sop;
  logic [num_inputs-1:0]  in_eop;
  logic [num_inputs-1:0]  in_ready;
  logic [num_inputs-1:0]  grant      [num_outputs];

  assign in_request[0] = request_0;
  assign in_request[1] = request_1;
  assign in_flit[0]    = flit_0;
  assign in_flit[1]    = flit_1;
  assign in_sop        = {sop_1, sop_0};
  assign in_eop        = {eop_1, eop_0};

  ////////////////////////////////////////////////////////////
  // per output arbitration and flit mux
  ////////////////////////////////////////////////////////////

  for (genvar o = 0; o < num_outputs; o++) begin : g_output
    logic [num_inputs-1:0] request_col;
    logic                  valid_sel;
    noc_flit_t             flit_sel;

    always_comb begin
      for (int i = 0; i < num_inputs; i++) begin
        request_col[i] = in_request[i][o];
      end
    end

    noc_output_arbiter i_noc_output_arbiter (
      .clk       (clk),
      .rst_n     (rst_n),
      .request   (request_col),
      .sop       (in_sop),
      .eop       (in_eop),
      .out_ready (out_ready[o]),
      .grant     (grant[o])
    );

    always_comb begin
      valid_sel = 1'b0;
      flit_sel  = in_flit[0];
      for (int i = 0; i < num_inputs; i++) begin
        if (grant[o][i]) begin
          valid_sel = request_col[i];
          flit_sel  = in_flit[i];
        end
      end
    end

    assign out_valid[o] = valid_sel;
    assign out_flit[o]  = flit_sel;
  end

  ////////////////////////////////////////////////////////////
  // ready steering
  ////////////////////////////////////////////////////////////

  // an input is granted by one output at most.
  always_comb begin
    in_ready = '0;
    for (int i = 0; i < num_inputs; i++) begin
      for (int o = 0; o < num_outputs; o++) begin
        if (grant[o][i] && out_ready[o]) begin
          in_ready[i] = 1'b1;
        end
      end
    end
  end

  assign ready_0 = in_ready[0];
  assign ready_1 = in_ready[1];

endmodule

/* noc_router_slice.sv */
`timescale 1ns/100ps

module noc_router_slice
  import noc_config_pkg::*;
  import noc_flit_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [id_x_width-1:0]       id_x,
  input  logic [id_y_width-1:0]       id_y,
  input  logic                        in_valid_0,
  input  noc_flit_t                   in_flit_0,
  output logic                        in_ready_0,
  input  logic                        in_valid_1,
  input  noc_flit_t                   in_flit_1,
  output logic                        in_ready_1,
  output logic [num_outputs-1:0]      out_valid,
  output noc_flit_t [num_outputs-1:0] out_flit,
  input  logic [num_outputs-1:0]      out_ready
);

  logic [num_outputs-1:0] request_0;
  logic [num_outputs-1:0] request_1;
  logic                   sop_0;
  logic                   sop_1;
  logic                   eop_0;
  logic                   eop_1;
  logic                   ready_0;
  logic                   ready_1;

  noc_route_selector i_noc_route_selector_0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .id_x     (id_x),
    .id_y     (id_y),
    .in_valid (in_valid_0),
    .in_flit  (in_flit_0),
    .in_ready (in_ready_0),
    .request  (request_0),
    .sop      (sop_0),
    .eop      (eop_0),
    .ready    (ready_0)
  );

  noc_route_selector i_noc_route_selector_1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .id_x     (id_x),
    .id_y     (id_y),
    .in_valid (in_valid_1),
    .in_flit  (in_flit_1),
    .in_ready (in_ready_1),
    .request  (request_1),
    .sop      (sop_1),
    .eop      (eop_1),
    .ready    (ready_1)
  );

  noc_output_switch i_noc_output_switch (
    .clk       (clk),
    .rst_n     (rst_n),
    .request_0 (request_0),
    .request_1 (request_1),
    .flit_0    (in_flit_0),
    .flit_1    (in_flit_1),
    .sop_0     (sop_0),
    .sop_1     (sop_1),
    .eop_0     (eop_0),
    .eop_1     (eop_1),
    .ready_0   (ready_0),
    .ready_1   (ready_1),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

endmodule

/* tb_noc_router_slice.sv */
`timescale 1ns/100ps

module tb_noc_router_slice
  import noc_config_pkg::*;
  import noc_flit_pkg::*;
();

  localparam int node_x   = 3;
  localparam int node_y   = 3;
  localparam int max_rows = 32;

  typedef struct {
    string name;
    int    port;
    int    start;
    int    flits;
    int    dest_out;
  } row_t;

  logic                        clk;
  logic                        rst_n = 1'b0;
  logic [id_x_width-1:0]       id_x = id_x_width'(node_x);
  logic [id_y_width-1:0]       id_y = id_y_width'(node_y);
  logic                        in_valid [num_inputs] = '{default: 1'b0};
  noc_flit_t                   in_flit [num_inputs] = '{default: '0};
  logic                        in_ready [num_inputs];
  logic [num_outputs-1:0]      out_valid;
  noc_flit_t [num_outputs-1:0] out_flit;
  logic [num_outputs-1:0]      out_ready = '1;

  row_t                   rows [$];
  noc_flit_t              pkt_flits [max_rows][4];
  noc_flit_t              expected_q [num_outputs][num_inputs][$];
  int                     cur_row [num_inputs] = '{default: 0};
  int                     cur_out [num_inputs] = '{default: -1};
  int                     owner [num_outputs] = '{default: -1};
  int                     last_src [num_outputs] = '{default: -1};
  logic [num_outputs-1:0] prev_ready = '1;
  int                     seed = 32'h28c86086;
  int                     cycle = 0;
  int                     cycle_limit = 0;
  int                     total_flits = 0;
  int                     stall_lo = 32'h7fffffff;
  int                     stall_hi = 0;

  noc_router_slice i_noc_router_slice (
    .clk        (clk),
    .rst_n      (rst_n),
    .id_x       (id_x),
    .id_y       (id_y),
    .in_valid_0 (in_valid[0]),
    .in_flit_0  (in_flit[0]),
    .in_ready_0 (in_ready[0]),
    .in_valid_1 (in_valid[1]),
    .in_flit_1  (in_flit[1]),
    .in_ready_1 (in_ready[1]),
    .out_valid  (out_valid),
    .out_flit   (out_flit),
    .out_ready  (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_failed();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      stop_failed();
    end
  endtask

  // dimension order rule seen from node (3,3).
  function automatic int expected_port(input int dx, input int dy, input noc_routing_mode_t mode);
    int x_port;
    int y_port;
    x_port = (dx > node_x) ? port_x_plus : (dx < node_x) ? port_x_minus : -1;
    y_port = (dy > node_y) ? port_y_plus : (dy < node_y) ? port_y_minus : -1;
    if (x_port < 0 && y_port < 0) begin
      return port_local;
    end
    if (mode == routing_x_y) begin
      return (x_port >= 0) ? x_port : y_port;
    end
    return (y_port >= 0) ? y_port : x_port;
  endfunction

  task automatic add_row(input string name, input int port, input int dx, input int dy,
                         input noc_routing_mode_t mode, input int flits, input int start,
                         input bit stall);
    row_t        row;
    noc_flit_t   f;
    logic [31:0] garbage;
    row.name     = name;
    row.port     = port;
    row.start    = start;
    row.flits    = flits;
    row.dest_out = expected_port(dx, dy, mode);
    for (int k = 0; k < flits; k++) begin
      garbage        = $random(seed);
      f.head         = (k == 0);
      f.tail         = (k == flits - 1);
      f.routing_mode = noc_routing_mode_t'(garbage[0]);  // junk outside the head.
      f.dest_x       = garbage[3:1];
      f.dest_y       = garbage[6:4];
      f.payload      = $random(seed);
      if (k == 0) begin
        f.routing_mode = mode;
        f.dest_x       = id_x_width'(dx);
        f.dest_y       = id_y_width'(dy);
      end
      pkt_flits[rows.size()][k] = f;
      expected_q[row.dest_out][port].push_back(f);
    end
    if (stall && start < stall_lo) begin
      stall_lo = start;
    end
    total_flits += flits;
    rows.push_back(row);
  endtask

  // walks the table for one input port.
  task automatic run_input(input int port);
    for (int r = 0; r < rows.size(); r++) begin
      if (rows[r].port == port) begin
        while (cycle < rows[r].start) @(posedge clk);
        for (int k = 0; k < rows[r].flits; k++) begin
          in_valid[port] <= 1'b1;
          in_flit[port]  <= pkt_flits[r][k];
          cur_row[port]  <= r;
          cur_out[port]  <= rows[r].dest_out;
          do @(posedge clk); while (!in_ready[port]);
        end
        in_valid[port] <= 1'b0;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // output monitors and scoreboards
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    int src;
    int other;
    if (rst_n) begin
      for (int o = 0; o < num_outputs; o++) begin
        if (out_valid[o] && out_ready[o]) begin
          if (owner[o] < 0) begin
            src = -1;
            for (int i = 0; i < num_inputs; i++) begin
              if (in_valid[i] && cur_out[i] == o && in_flit[i] == out_flit[o]) begin
                src = i;
              end
            end
            if (src < 0) begin
              $display("ERROR: output %0d passed a flit that no input sent to it", o);
              stop_failed();
            end
            other = 1 - src;
            // both heads waiting, winner alternates.
            if (prev_ready[o] && in_valid[other] && in_flit[other].head &&
                cur_out[other] == o) begin
              check_value({rows[cur_row[src]].name, " turn"},
                          (last_src[o] == 0) ? 1 : 0, src);
            end
            owner[o] = src;
          end
          src = owner[o];
          if (expected_q[o][src].size() == 0) begin
            $display("ERROR: output %0d delivered more flits than input %0d sent", o, src);
            stop_failed();
          end
          check_value(rows[cur_row[src]].name, expected_q[o][src].pop_front(), out_flit[o]);
          if (out_flit[o].tail) begin
            last_src[o] = src;
            owner[o]    = -1;  // packet closed.
          end
        end
        prev_ready[o] = out_ready[o];
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (cycle >= stall_lo && cycle < stall_hi) begin
        out_ready <= num_outputs'($random(seed));  // back-pressure phase.
      end else begin
        out_ready <= '1;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      cycle <= 0;
    end else begin
      cycle <= cycle + 1;
      if (cycle > cycle_limit) begin
        $display("ERROR: timeout, run exceeded %0d cycles", cycle_limit);
        stop_failed();
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  initial begin
    int pending;
    add_row("xy_east",    0, 5, 3, routing_x_y, 2, 2, 1'b0);
    add_row("xy_west",    1, 1, 3, routing_x_y, 1, 2, 1'b0);
    add_row("xy_north",   0, 3, 6, routing_x_y, 3, 8, 1'b0);
    add_row("xy_south",   1, 3, 0, routing_x_y, 2, 8, 1'b0);
    add_row("xy_diag_ne", 0, 6, 6, routing_x_y, 1, 14, 1'b0);
    add_row("yx_diag_ne", 1, 6, 6, routing_y_x, 1, 14, 1'b0);
    add_row("yx_diag_sw", 0, 0, 1, routing_y_x, 2, 18, 1'b0);
    add_row("xy_diag_sw", 1, 0, 1, routing_x_y, 2, 18, 1'b0);
    add_row("local_0",    0, 3, 3, routing_x_y, 1, 24, 1'b0);
    add_row("local_1",    1, 3, 3, routing_y_x, 2, 24, 1'b0);
    add_row("body_route", 0, 7, 2, routing_x_y, 4, 30, 1'b0);
    add_row("next_head",  0, 2, 5, routing_x_y, 3, 31, 1'b0);
    add_row("same_out_a", 0, 3, 7, routing_x_y, 3, 50, 1'b0);  // all four share y plus.
    add_row("same_out_b", 1, 4, 5, routing_y_x, 3, 50, 1'b0);
    add_row("same_out_c", 0, 3, 5, routing_y_x, 2, 51, 1'b0);
    add_row("same_out_d", 1, 0, 6, routing_y_x, 2, 51, 1'b0);
    add_row("stall_a",    0, 6, 1, routing_x_y, 4, 70, 1'b1);
    add_row("stall_b",    1, 2, 6, routing_y_x, 4, 70, 1'b1);
    add_row("stall_c",    0, 3, 3, routing_x_y, 3, 72, 1'b1);
    add_row("stall_d",    1, 5, 5, routing_y_x, 4, 72, 1'b1);
    add_row("stall_e",    0, 0, 0, routing_y_x, 2, 72, 1'b1);
    cycle_limit = 20 * total_flits + 100;
    stall_hi    = stall_lo + 60;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    fork
      run_input(0);
      run_input(1);
    join
    repeat (4) @(posedge clk);
    pending = 0;
    for (int o = 0; o < num_outputs; o++) begin
      for (int i = 0; i < num_inputs; i++) begin
        pending += expected_q[o][i].size();
      end
    end
    if (pending != 0) begin
      $display("ERROR: %0d expected flits never arrived", pending);
      stop_failed();
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

/* filelist.f */
noc_config_pkg.sv
noc_flit_pkg.sv
noc_route_selector.sv
noc_output_arbiter.sv
noc_output_switch.sv
noc_router_slice.sv
tb_noc_router_slice.sv

/* Bender.yml */
package:
  name: noc_router_slice

sources:
  - noc_config_pkg.sv
  - noc_flit_pkg.sv
  - noc_route_selector.sv
  - noc_output_arbiter.sv
  - noc_output_switch.sv
  - noc_router_slice.sv
  - target: test
    files:
      - tb_noc_router_slice.sv
